//--- design/pifo_cfg.svh
`ifndef PIFO_CFG_SVH
`define PIFO_CFG_SVH

// number of queue slots
`define PIFO_DEPTH 8

// priority width, lower value ranks first
`define PIFO_PRIO_W 8

// application id width, the pop mask has one bit per id
`define PIFO_APP_W 3

// payload bits above the app id
`define PIFO_PAYLOAD_W 13

// full data word as pushed and popped
`define PIFO_WORD_W (`PIFO_PAYLOAD_W + `PIFO_APP_W)

`endif

//--- design/pifo_pkg.sv
`include "pifo_cfg.svh"

package pifo_pkg;

  // one data word, seen whole or split into fields
  typedef union packed {
    logic [`PIFO_WORD_W-1:0] raw;
    struct packed {
      logic [`PIFO_PAYLOAD_W-1:0] payload;
      // low bits select the mask bit on pop
      logic [`PIFO_APP_W-1:0]     app_id;
    } fields;
  } entry_word_u;

  typedef logic [`PIFO_PRIO_W-1:0] prio_t;

  // slot index
  typedef logic [$clog2(`PIFO_DEPTH)-1:0] idx_t;

  // one extra bit so a full queue fits
  typedef logic [$clog2(`PIFO_DEPTH):0] cnt_t;

  // eligibility mask, bit n enables app id n
  typedef logic [(1 << `PIFO_APP_W)-1:0] app_mask_t;

endpackage

//--- design/pifo_ctrl.sv
`timescale 1ns/1ns

module pifo_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic push_req,
  input  logic pop_req,
  output logic push_ack,
  output logic pop_ack,
  output logic do_push,
  output logic do_pop
);

  localparam logic [1:0] IDLE         = 2'd0;
  localparam logic [1:0] PUSH_EXEC    = 2'd1;
  localparam logic [1:0] POP_EXEC     = 2'd2;
  localparam logic [1:0] WAIT_RELEASE = 2'd3;

  logic [1:0] state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      push_ack <= 1'b0;
      pop_ack  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // push wins when both ask in the same cycle
          if (push_req) begin
            state <= PUSH_EXEC;
          end else if (pop_req) begin
            state <= POP_EXEC;
          end
        end
        PUSH_EXEC: begin
          // store updates on this edge, ack goes up with it
          push_ack <= 1'b1;
          state    <= WAIT_RELEASE;
        end
        POP_EXEC: begin
          pop_ack <= 1'b1;
          state   <= WAIT_RELEASE;
        end
        WAIT_RELEASE: begin
          // the raised ack tells which req owns the slot
          if ((push_ack && !push_req) || (pop_ack && !pop_req)) begin
            push_ack <= 1'b0;
            pop_ack  <= 1'b0;
            state    <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // one-cycle strobes while executing
  assign do_push = (state == PUSH_EXEC);
  assign do_pop  = (state == POP_EXEC);

  // only one command owns the queue at a time
  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    !(push_ack && pop_ack));

endmodule

//--- design/pifo_occupancy.sv
`timescale 1ns/1ns
`include "pifo_cfg.svh"

module pifo_occupancy (
  input  logic           clk,
  input  logic           rst,
  input  logic           do_push,
  input  logic           do_pop,
  input  logic           hit,
  output pifo_pkg::cnt_t count,
  output logic           full
);

  import pifo_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (do_push && !full) begin
      count <= count + cnt_t'(1);
    end else if (do_pop && hit) begin
      // a missed pop leaves the queue alone
      count <= count - cnt_t'(1);
    end
  end

  // a push while full swaps one entry out, count saturates
  assign full = (count == cnt_t'(`PIFO_DEPTH));

  a_count_max: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_t'(`PIFO_DEPTH));

endmodule

//--- design/pifo_slot_finder.sv
`timescale 1ns/1ns
`include "pifo_cfg.svh"

module pifo_slot_finder (
  input  pifo_pkg::prio_t       prio_arr [`PIFO_DEPTH],
  input  pifo_pkg::entry_word_u word_arr [`PIFO_DEPTH],
  input  pifo_pkg::cnt_t        count,
  input  pifo_pkg::prio_t       push_prio,
  input  pifo_pkg::app_mask_t   pop_mask,
  output pifo_pkg::idx_t        push_idx,
  output pifo_pkg::idx_t        pop_idx,
  output logic                  push_beyond,
  output logic                  hit
);

  import pifo_pkg::*;

  logic [`PIFO_DEPTH-1:0] push_bmp;
  logic [`PIFO_DEPTH-1:0] pop_bmp;

  // position of the lowest set bit, zero when none
  function automatic idx_t lowest_set(input logic [`PIFO_DEPTH-1:0] bmp);
    idx_t pos;
    pos = '0;
    for (int i = `PIFO_DEPTH - 1; i >= 0; i--) begin
      if (bmp[i]) begin
        pos = idx_t'(i);
      end
    end
    return pos;
  endfunction

  always_comb begin
    for (int i = 0; i < `PIFO_DEPTH; i++) begin
      // strictly larger keeps equal priorities in arrival order
      push_bmp[i] = (cnt_t'(i) >= count) || (prio_arr[i] > push_prio);
      pop_bmp[i]  = (cnt_t'(i) < count) && pop_mask[word_arr[i].fields.app_id];
    end
  end

  assign push_idx    = lowest_set(push_bmp);
  assign pop_idx     = lowest_set(pop_bmp);

  // full queue and nothing worse than the new entry
  assign push_beyond = ~|push_bmp;
  assign hit         = |pop_bmp;

endmodule

//--- design/pifo_store.sv
`timescale 1ns/1ns
`include "pifo_cfg.svh"

module pifo_store (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  do_push,
  input  logic                  do_pop,
  input  logic                  hit,
  input  logic                  full,
  input  logic                  push_beyond,
  input  pifo_pkg::idx_t        push_idx,
  input  pifo_pkg::idx_t        pop_idx,
  input  pifo_pkg::prio_t       push_prio,
  input  pifo_pkg::entry_word_u push_data,
  output pifo_pkg::prio_t       prio_arr [`PIFO_DEPTH],
  output pifo_pkg::entry_word_u word_arr [`PIFO_DEPTH],
  output logic                  pop_hit,
  output pifo_pkg::prio_t       pop_prio,
  output pifo_pkg::entry_word_u pop_data,
  output logic                  drop_vld,
  output pifo_pkg::prio_t       drop_prio,
  output pifo_pkg::entry_word_u drop_data
);

  import pifo_pkg::*;

  // control flags
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_hit  <= 1'b0;
      drop_vld <= 1'b0;
    end else begin
      // drop is a single-cycle pulse
      drop_vld <= do_push && full;
      if (do_pop) begin
        pop_hit <= hit;
      end
    end
  end

  // entry array and result words
  always_ff @(posedge clk) begin
    if (do_push) begin
      if (full && push_beyond) begin
        // new entry ranks last, it goes straight out
        drop_prio <= push_prio;
        drop_data <= push_data;
      end else begin
        if (full) begin
          drop_prio <= prio_arr[`PIFO_DEPTH-1];
          drop_data <= word_arr[`PIFO_DEPTH-1];
        end
        // open a hole at the insert position
        for (int i = 1; i < `PIFO_DEPTH; i++) begin
          if (idx_t'(i) > push_idx) begin
            prio_arr[i] <= prio_arr[i-1];
            word_arr[i] <= word_arr[i-1];
          end
        end
        prio_arr[push_idx] <= push_prio;
        word_arr[push_idx] <= push_data;
      end
    end else if (do_pop && hit) begin
      pop_prio <= prio_arr[pop_idx];
      pop_data <= word_arr[pop_idx];
      // close the gap, the top slot keeps a stale copy past count
      for (int i = 0; i < `PIFO_DEPTH - 1; i++) begin
        if (idx_t'(i) >= pop_idx) begin
          prio_arr[i] <= prio_arr[i+1];
          word_arr[i] <= word_arr[i+1];
        end
      end
    end
  end

  // a drop only follows a push strobe and ranks no better than the last kept slot
  a_drop_after_push: assert property (@(posedge clk) disable iff (rst)
    drop_vld |-> $past(do_push) && (drop_prio >= prio_arr[`PIFO_DEPTH-1]));

endmodule

//--- design/pifo_top.sv
`timescale 1ns/1ns
`include "pifo_cfg.svh"

module pifo_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push_req,
  input  pifo_pkg::prio_t       push_prio,
  input  pifo_pkg::entry_word_u push_data,
  output logic                  push_ack,
  input  logic                  pop_req,
  input  pifo_pkg::app_mask_t   pop_mask,
  output logic                  pop_ack,
  output logic                  pop_hit,
  output pifo_pkg::prio_t       pop_prio,
  output pifo_pkg::entry_word_u pop_data,
  output logic                  drop_vld,
  output pifo_pkg::prio_t       drop_prio,
  output pifo_pkg::entry_word_u drop_data
);

  import pifo_pkg::*;

  logic        do_push;
  logic        do_pop;
  logic        hit;
  logic        full;
  logic        push_beyond;
  idx_t        push_idx;
  idx_t        pop_idx;
  cnt_t        count;
  prio_t       prio_arr [`PIFO_DEPTH];
  entry_word_u word_arr [`PIFO_DEPTH];

  pifo_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .push_req (push_req),
    .pop_req  (pop_req),
    .push_ack (push_ack),
    .pop_ack  (pop_ack),
    .do_push  (do_push),
    .do_pop   (do_pop)
  );

  pifo_occupancy u_occupancy (
    .clk     (clk),
    .rst     (rst),
    .do_push (do_push),
    .do_pop  (do_pop),
    .hit     (hit),
    .count   (count),
    .full    (full)
  );

  // sees the request fields directly, they are held until ack
  pifo_slot_finder u_slot_finder (
    .prio_arr    (prio_arr),
    .word_arr    (word_arr),
    .count       (count),
    .push_prio   (push_prio),
    .pop_mask    (pop_mask),
    .push_idx    (push_idx),
    .pop_idx     (pop_idx),
    .push_beyond (push_beyond),
    .hit         (hit)
  );

  pifo_store u_store (
    .clk         (clk),
    .rst         (rst),
    .do_push     (do_push),
    .do_pop      (do_pop),
    .hit         (hit),
    .full        (full),
    .push_beyond (push_beyond),
    .push_idx    (push_idx),
    .pop_idx     (pop_idx),
    .push_prio   (push_prio),
    .push_data   (push_data),
    .prio_arr    (prio_arr),
    .word_arr    (word_arr),
    .pop_hit     (pop_hit),
    .pop_prio    (pop_prio),
    .pop_data    (pop_data),
    .drop_vld    (drop_vld),
    .drop_prio   (drop_prio),
    .drop_data   (drop_data)
  );

endmodule

//--- verification/pifo_tb.sv
`timescale 1ns/1ns
`include "pifo_cfg.svh"

module pifo_tb;

  import pifo_pkg::*;

  typedef logic [`PIFO_WORD_W-1:0] word_t;

  localparam int LIMIT = 16;

  logic        clk;
  logic        rst;
  logic        push_req;
  prio_t       push_prio;
  entry_word_u push_data;
  logic        push_ack;
  logic        pop_req;
  app_mask_t   pop_mask;
  logic        pop_ack;
  logic        pop_hit;
  prio_t       pop_prio;
  entry_word_u pop_data;
  logic        drop_vld;
  prio_t       drop_prio;
  entry_word_u drop_data;

  // reference queue, best entry at index 0
  prio_t q_prio [$];
  word_t q_word [$];

  // expected results of the command in flight
  logic  exp_drop;
  prio_t exp_drop_prio;
  word_t exp_drop_word;
  logic  exp_hit;
  prio_t exp_pop_prio;
  word_t exp_pop_word;

  logic [15:0] lfsr = 16'd45178;
  logic        rst_q = 1'b0;
  logic        push_req_q = 1'b0;
  logic        pop_req_q = 1'b0;
  int          push_wait;
  int          pop_wait;
  int          err_cnt;
  int          timeout_cnt;

  pifo_top u_pifo_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // edges a request has waited while the controller was free
  always @(posedge clk) begin
    rst_q      <= rst;
    push_req_q <= push_req;
    pop_req_q  <= pop_req;
    push_wait  <= (push_req && !push_ack && !pop_ack) ? push_wait + 1 : 0;
    pop_wait   <= (pop_req && !pop_ack && !push_req && !push_ack) ? pop_wait + 1 : 0;
  end

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    err_cnt++;
    $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
  endtask

  a_reset_idle: assert property (@(posedge clk)
    rst_q && !rst |-> !(push_ack || pop_ack || drop_vld))
    else report_value("push_ack/pop_ack/drop_vld",
                      32'($sampled({push_ack, pop_ack, drop_vld})), 32'd0);
  a_push_delay: assert property (@(posedge clk) disable iff (rst)
    $rose(push_ack) |-> push_wait == 2)
    else report_value("push_ack delay", 32'($sampled(push_wait)), 32'd2);
  a_pop_delay: assert property (@(posedge clk) disable iff (rst)
    $rose(pop_ack) |-> pop_wait == 2)
    else report_value("pop_ack delay", 32'($sampled(pop_wait)), 32'd2);
  // ack follows req down one edge later
  a_push_release: assert property (@(posedge clk) disable iff (rst)
    push_ack |=> push_ack == push_req_q)
    else report_value("push_ack", 32'($sampled(push_ack)), 32'($sampled(push_req_q)));
  a_pop_release: assert property (@(posedge clk) disable iff (rst)
    pop_ack |=> pop_ack == pop_req_q)
    else report_value("pop_ack", 32'($sampled(pop_ack)), 32'($sampled(pop_req_q)));
  a_push_first: assert property (@(posedge clk) disable iff (rst)
    $rose(pop_ack) |-> !push_req)
    else report_value("push_req", 32'($sampled(push_req)), 32'd0);
  a_drop_flag: assert property (@(posedge clk) disable iff (rst)
    $rose(push_ack) |-> drop_vld == exp_drop)
    else report_value("drop_vld", 32'($sampled(drop_vld)), 32'($sampled(exp_drop)));
  a_drop_pulse: assert property (@(posedge clk) disable iff (rst)
    drop_vld |=> !drop_vld)
    else report_value("drop_vld", 32'($sampled(drop_vld)), 32'd0);
  a_drop_prio: assert property (@(posedge clk) disable iff (rst)
    $rose(push_ack) && exp_drop |-> drop_prio == exp_drop_prio)
    else report_value("drop_prio", 32'($sampled(drop_prio)), 32'($sampled(exp_drop_prio)));
  a_drop_data: assert property (@(posedge clk) disable iff (rst)
    $rose(push_ack) && exp_drop |-> drop_data.raw == exp_drop_word)
    else report_value("drop_data", 32'($sampled(drop_data.raw)), 32'($sampled(exp_drop_word)));
  a_pop_hit: assert property (@(posedge clk) disable iff (rst)
    pop_ack |-> pop_hit == exp_hit)
    else report_value("pop_hit", 32'($sampled(pop_hit)), 32'($sampled(exp_hit)));
  a_pop_prio: assert property (@(posedge clk) disable iff (rst)
    pop_ack && exp_hit |-> pop_prio == exp_pop_prio)
    else report_value("pop_prio", 32'($sampled(pop_prio)), 32'($sampled(exp_pop_prio)));
  a_pop_data: assert property (@(posedge clk) disable iff (rst)
    pop_ack && exp_hit |-> pop_data.raw == exp_pop_word)
    else report_value("pop_data", 32'($sampled(pop_data.raw)), 32'($sampled(exp_pop_word)));

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  // new entry lands after its equals, a full queue loses its worst entry
  task automatic sorted_insert(input prio_t p, input word_t w);
    int pos;
    pos = 0;
    while (pos < q_prio.size() && q_prio[pos] <= p) begin
      pos++;
    end
    exp_drop <= (q_prio.size() == `PIFO_DEPTH);
    if (pos == `PIFO_DEPTH) begin
      exp_drop_prio <= p;
      exp_drop_word <= w;
    end else begin
      q_prio.insert(pos, p);
      q_word.insert(pos, w);
      if (q_prio.size() > `PIFO_DEPTH) begin
        exp_drop_prio <= q_prio.pop_back();
        exp_drop_word <= q_word.pop_back();
      end
    end
  endtask

  // first entry whose app id is enabled leaves the queue
  task automatic eligible_remove(input app_mask_t m);
    int pos;
    pos = 0;
    while (pos < q_word.size() && !m[q_word[pos][`PIFO_APP_W-1:0]]) begin
      pos++;
    end
    exp_hit <= (pos < q_word.size());
    if (pos < q_word.size()) begin
      exp_pop_prio <= q_prio[pos];
      exp_pop_word <= q_word[pos];
      q_prio.delete(pos);
      q_word.delete(pos);
    end
  endtask

  task automatic wait_ack(input bit on_pop, input logic level);
    int edges;
    edges = 0;
    while ((on_pop ? pop_ack : push_ack) !== level && edges < LIMIT) begin
      @(posedge clk);
      edges++;
    end
    if ((on_pop ? pop_ack : push_ack) !== level) begin
      timeout_cnt++;
      $display("timeout at %0t: %s did not reach %0b within %0d cycles",
               $time, on_pop ? "pop_ack" : "push_ack", level, LIMIT);
    end
  endtask

  // both requests may go up together, push is served first
  task automatic run_command(input bit with_push, input bit with_pop, input prio_t p,
                             input word_t w, input app_mask_t m);
    if (with_push) begin
      sorted_insert(p, w);
      push_prio     <= p;
      push_data.raw <= w;
      push_req      <= 1'b1;
    end
    if (with_pop) begin
      eligible_remove(m);
      pop_mask <= m;
      pop_req  <= 1'b1;
    end
    if (with_push) begin
      wait_ack(1'b0, 1'b1);
      push_req <= 1'b0;
      wait_ack(1'b0, 1'b0);
    end
    if (with_pop) begin
      wait_ack(1'b1, 1'b1);
      pop_req <= 1'b0;
      wait_ack(1'b1, 1'b0);
    end
  endtask

  task automatic random_push(input int prio_bits, input prio_t floor);
    logic [15:0] p;
    logic [15:0] w;
    take_bits(prio_bits, p);
    take_bits(`PIFO_WORD_W, w);
    run_command(1'b1, 1'b0, p[`PIFO_PRIO_W-1:0] | floor, word_t'(w), '0);
  endtask

  task automatic random_pop();
    logic [15:0] m;
    take_bits(1 << `PIFO_APP_W, m);
    run_command(1'b0, 1'b1, '0, '0, app_mask_t'(m));
  endtask

  initial begin
    logic [15:0] sel;
    rst       = 1'b1;
    push_req  = 1'b0;
    push_prio = '0;
    push_data = '0;
    pop_req   = 1'b0;
    pop_mask  = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // two priority bits give plenty of ties
    repeat (6) random_push(2, 8'h00);
    repeat (7) run_command(1'b0, 1'b1, '0, '0, '1);
    run_command(1'b1, 1'b1, 8'h20, 16'h1235, '1);
    repeat (3) random_push(8, 8'h00);
    run_command(1'b1, 1'b1, 8'h00, 16'h0004, 8'h10);
    // masked pops, an empty mask misses
    repeat (4) random_push(8, 8'h00);
    run_command(1'b0, 1'b1, '0, '0, '0);
    repeat (6) random_pop();
    while (q_prio.size() > 0) begin
      run_command(1'b0, 1'b1, '0, '0, '1);
    end
    while (q_prio.size() < `PIFO_DEPTH) begin
      random_push(8, 8'h10);
    end
    // better than the worst, so the last entry falls out
    run_command(1'b1, 1'b0, 8'h01, 16'hABC5, '0);
    // no better than the worst, the pushed entry itself drops
    run_command(1'b1, 1'b0, 8'hFF, 16'h7777, '0);
    repeat (9) run_command(1'b0, 1'b1, '0, '0, '1);
    repeat (40) begin
      take_bits(1, sel);
      if (sel[0]) begin
        random_push(3, 8'h00);
      end else begin
        random_pop();
      end
    end
    repeat (2) @(posedge clk);
    $display("value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/pifo_pkg.sv
design/pifo_ctrl.sv
design/pifo_occupancy.sv
design/pifo_slot_finder.sv
design/pifo_store.sv
design/pifo_top.sv
verification/pifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the PIFO testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f compile.f \
  --top-module pifo_tb -o pifo_sim > build.log 2>&1 \
  && ./obj_dir/pifo_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
